//--- bench/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// reference behavior of the ALU, 6-bit flag vector ordered S Z H V N C

function automatic logic [31:0] mask_of(input logic [2:0] wd);
    return wd[0] ? 32'h0000_00ff : (wd[1] ? 32'h0000_ffff : 32'hffff_ffff);
endfunction

function automatic logic top_bit(input logic [31:0] x, input logic [2:0] wd);
    logic [31:0] m;
    m = mask_of(wd);
    return (x & (m ^ (m >> 1))) != 0;
endfunction

function automatic logic even_parity(input logic [31:0] x, input logic [2:0] wd);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < (wd[0] ? 8 : 16); i++) begin // long counts the low word only
        ones += x[i];
    end
    return (ones % 2) == 0;
endfunction

function automatic logic [7:0] pack_flags(input logic [5:0] f);
    return {f[alu_pkg::FLAG_S], f[alu_pkg::FLAG_Z], 1'b0, f[alu_pkg::FLAG_H], 1'b0,
            f[alu_pkg::FLAG_V], f[alu_pkg::FLAG_N], f[alu_pkg::FLAG_C]};
endfunction

function automatic void arith_model(input alu_pkg::alu_op_t op, input logic [2:0] wd,
                                    input logic [31:0] d, input logic [31:0] s,
                                    input logic [5:0] f_in,
                                    output logic [31:0] res, output logic [5:0] f_out);
    logic [31:0] m;
    logic [31:0] a;
    logic [31:0] b;
    logic        sub;
    logic        h;
    longint      ci;
    longint      ua;
    longint      ub;
    longint      sa;
    longint      sb;
    longint      span;
    longint      full;
    f_out = f_in;
    res   = s;
    if (op == alu_pkg::OP_MOVE) begin
        return; // plain load, flags untouched
    end
    m    = mask_of(wd);
    sub  = op inside {alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP, alu_pkg::OP_DEC,
                      alu_pkg::OP_NEG};
    ci   = (op == alu_pkg::OP_ADC || op == alu_pkg::OP_SBC) ? f_in[alu_pkg::FLAG_C] : 0;
    a    = (op == alu_pkg::OP_NEG) ? 32'd0 : d;
    b    = (op == alu_pkg::OP_NEG) ? d : s;
    res  = sub ? a - b - ci[31:0] : a + b + ci[31:0];
    ua   = longint'(a & m);
    ub   = longint'(b & m);
    span = longint'(m) + 1;
    sa   = top_bit(a, wd) ? ua - span : ua;
    sb   = top_bit(b, wd) ? ub - span : ub;
    full = sub ? sa - sb - ci : sa + sb + ci; // true signed value
    h    = sub ? (int'(a[3:0]) < int'(b[3:0]) + ci) : (int'(a[3:0]) + int'(b[3:0]) + ci > 15);
    f_out[alu_pkg::FLAG_S] = top_bit(res, wd);
    f_out[alu_pkg::FLAG_Z] = (res & m) == 0;
    f_out[alu_pkg::FLAG_H] = h;
    f_out[alu_pkg::FLAG_V] = (full >= span / 2) || (full < -(span / 2));
    f_out[alu_pkg::FLAG_N] = sub;
    f_out[alu_pkg::FLAG_C] = sub ? (ua < ub + ci) : (ua + ub + ci > longint'(m));
    if (op inside {alu_pkg::OP_INC, alu_pkg::OP_DEC}) begin
        f_out[alu_pkg::FLAG_C] = f_in[alu_pkg::FLAG_C];
        if (!wd[0]) begin // wider counters only touch H
            f_out = f_in;
            f_out[alu_pkg::FLAG_H] = h;
        end
    end
endfunction

function automatic void logic_model(input alu_pkg::alu_op_t op, input logic [2:0] wd,
                                    input logic [31:0] d, input logic [31:0] s,
                                    input logic [5:0] f_in,
                                    output logic [31:0] res, output logic [5:0] f_out);
    int k;
    k     = s[3:0]; // bit number
    res   = d;
    f_out = f_in;
    case (op)
        alu_pkg::OP_AND: res = d & s;
        alu_pkg::OP_OR:  res = d | s;
        alu_pkg::OP_XOR: res = d ^ s;
        alu_pkg::OP_SET: res[k] = 1'b1;
        alu_pkg::OP_RES: res[k] = 1'b0;
        alu_pkg::OP_CHG: res[k] = ~d[k];
        alu_pkg::OP_CPL: begin
            res = ~d;
            f_out[alu_pkg::FLAG_H] = 1'b1;
            f_out[alu_pkg::FLAG_N] = 1'b1;
        end
        alu_pkg::OP_BIT, alu_pkg::OP_TSET: begin
            if (op == alu_pkg::OP_TSET) begin
                res[k] = 1'b1;
            end
            f_out[alu_pkg::FLAG_Z] = ~d[k];
            f_out[alu_pkg::FLAG_H] = 1'b1;
            f_out[alu_pkg::FLAG_N] = 1'b0;
        end
        default: ;
    endcase
    if (op inside {alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR}) begin
        f_out = {top_bit(res, wd), (res & mask_of(wd)) == 0, op == alu_pkg::OP_AND,
                 even_parity(res, wd), 1'b0, 1'b0};
    end
endfunction

function automatic void shift_model(input alu_pkg::alu_op_t op, input logic [2:0] wd,
                                    input logic [31:0] d, input logic [3:0] cnt,
                                    input logic c_in,
                                    output logic [31:0] res, output logic [5:0] f_out);
    logic [31:0] m;
    logic [31:0] v;
    logic        c;
    logic        top;
    logic        fill;
    int          steps;
    int          i;
    m     = mask_of(wd);
    v     = d & m;
    c     = c_in;
    steps = (cnt == 4'd0) ? 16 : int'(cnt);
    for (i = 0; i < steps; i++) begin // one bit per step at the operand width
        top = top_bit(v, wd);
        if (op inside {alu_pkg::OP_RLC, alu_pkg::OP_RL, alu_pkg::OP_SLA, alu_pkg::OP_SLL}) begin
            fill = (op == alu_pkg::OP_RLC) ? top : (op == alu_pkg::OP_RL) ? c : 1'b0;
            v    = ((v << 1) | {31'd0, fill}) & m;
            c    = top;
        end else begin
            fill = (op == alu_pkg::OP_RRC) ? v[0] : (op == alu_pkg::OP_RR) ? c :
                   (op == alu_pkg::OP_SRA) ? top : 1'b0;
            c    = v[0];
            v    = (v >> 1) | (fill ? (m ^ (m >> 1)) : 32'd0);
        end
    end
    res   = v;
    f_out = {top_bit(v, wd), v == 0, 1'b0, even_parity(v, wd), 1'b0, c};
endfunction

function automatic logic [5:0] carry_op_model(input alu_pkg::alu_op_t op,
                                              input logic [5:0] f_in);
    logic [5:0] f;
    f = f_in;
    f[alu_pkg::FLAG_N] = 1'b0;
    case (op)
        alu_pkg::OP_SCF, alu_pkg::OP_RCF: begin
            f[alu_pkg::FLAG_C] = (op == alu_pkg::OP_SCF);
            f[alu_pkg::FLAG_H] = 1'b0;
        end
        alu_pkg::OP_CCF: f[alu_pkg::FLAG_C] = ~f_in[alu_pkg::FLAG_C];
        alu_pkg::OP_ZCF: f[alu_pkg::FLAG_C] = ~f_in[alu_pkg::FLAG_Z]; // carry from inverted Z
        default: ;
    endcase
    return f;
endfunction

`endif

//--- bench/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    `include "alu_model.svh"

    logic                        clk;
    logic                        rst;
    alu_pkg::alu_op_t            op;
    alu_pkg::width_t             w;
    logic [31:0]                 op0;
    logic [31:0]                 op1;
    logic [31:0]                 imm;
    logic                        sel_imm;
    logic [31:0]                 dout;
    alu_pkg::width_t             result_we;
    logic [7:0]                  flags;
    logic                        busy;
    int                          errors;
    int                          ops_run;
    logic [31:0]                 seed;
    logic [5:0]                  mf;      // expected F
    logic [5:0]                  mf_dash; // expected F'
    logic [31:0]                 mdout;
    logic [31:0]                 mknown;  // dout bits the model can predict

    alu_top uut (
        .clk, .rst, .op, .w, .op0, .op1, .imm, .sel_imm,
        .dout, .result_we, .flags, .busy
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #1_000_000;
        $display("Simulation time limit reached before the test finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] step_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] a;
        logic [31:0] b;
        a = step_rand();
        b = step_rand();
        return {a[31:16], b[31:16]}; // high halves, low LCG bits are weak
    endfunction

    function automatic int rand_below(input int k);
        logic [31:0] r;
        r = step_rand();
        return int'(r[31:8]) % k;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
    endtask

    task automatic run_op(input alu_pkg::alu_op_t o, input logic [2:0] wd,
                          input logic [31:0] d, input logic [31:0] s,
                          input logic [31:0] im, input logic si);
        logic [31:0]     src;
        logic [31:0]     res;
        logic [5:0]      fnew;
        logic            writes;
        logic            shift;
        alu_pkg::width_t exp_we;
        int              n;
        int              cycles;
        src    = si ? im : s;
        shift  = o inside {alu_pkg::OP_RLC, alu_pkg::OP_RRC, alu_pkg::OP_RL, alu_pkg::OP_RR,
                           alu_pkg::OP_SLA, alu_pkg::OP_SRA, alu_pkg::OP_SLL, alu_pkg::OP_SRL};
        writes = !(o inside {alu_pkg::OP_CP, alu_pkg::OP_BIT, alu_pkg::OP_SCF, alu_pkg::OP_RCF,
                             alu_pkg::OP_CCF, alu_pkg::OP_ZCF, alu_pkg::OP_EXFF});
        n      = (src[3:0] == 4'd0) ? 16 : int'(src[3:0]);
        res    = d;
        fnew   = mf;
        if (shift) begin
            shift_model(o, wd, d, src[3:0], mf[alu_pkg::FLAG_C], res, fnew);
        end else if (o <= alu_pkg::OP_NEG) begin
            arith_model(o, wd, d, src, mf, res, fnew);
        end else if (o <= alu_pkg::OP_TSET) begin
            logic_model(o, wd, d, src, mf, res, fnew);
        end else if (o == alu_pkg::OP_EXFF) begin
            fnew    = mf_dash;
            mf_dash = mf;
        end else begin
            fnew = carry_op_model(o, mf);
        end
        ops_run++;

        @(negedge clk);
        op      = o;
        w       = wd;
        op0     = d;
        op1     = s;
        imm     = im;
        sel_imm = si;
        @(negedge clk);
        w = alu_pkg::W_NONE; // one-cycle strobe

        if (shift) begin
            cycles = 0;
            while (busy && cycles <= 20) begin
                @(negedge clk);
                cycles++;
            end
            if (busy) begin
                errors++;
                $display("Timeout: busy still high %0d cycles into %s", cycles, o.name());
            end else if (cycles != n - 1) begin
                report_mismatch(o.name(), "busy cycles", n - 1, cycles);
            end
        end

        exp_we = writes ? wd : alu_pkg::W_NONE;
        if (result_we !== exp_we) report_mismatch(o.name(), "result_we", exp_we, result_we);
        if (writes) begin
            mdout  = res;
            mknown = mask_of(wd);
        end
        if ((dout & mknown) !== (mdout & mknown)) begin
            report_mismatch(o.name(), "dout", mdout & mknown, dout & mknown);
        end
        mf = fnew;
        if (flags !== pack_flags(mf)) report_mismatch(o.name(), "flags", pack_flags(mf), flags);
    endtask

    initial begin
        alu_pkg::alu_op_t o;
        logic [2:0]       wd;
        logic [31:0]      d;
        logic [31:0]      s;
        logic [31:0]      im;
        logic             si;
        int               i;
        int               n;
        int               wi;
        seed    = 32'hef04_23f8;
        errors  = 0;
        ops_run = 0;
        mf      = '0;
        mf_dash = '0;
        mdout   = '0;
        mknown  = '1;
        rst     = 1'b1;
        op      = alu_pkg::OP_MOVE;
        w       = alu_pkg::W_NONE;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (dout !== 32'd0) report_mismatch("reset", "dout", 32'd0, dout);
        if (flags !== 8'd0) report_mismatch("reset", "flags", 32'd0, flags);
        if (busy !== 1'b0) report_mismatch("reset", "busy", 32'd0, busy);
        if (result_we !== alu_pkg::W_NONE) report_mismatch("reset", "result_we", 32'd0, result_we);

        // F' is clear after reset, so the first exchange shows zero flags
        run_op(alu_pkg::OP_SCF, alu_pkg::W_BYTE, 32'd0, 32'd0, 32'd0, 1'b0);
        run_op(alu_pkg::OP_EXFF, alu_pkg::W_BYTE, 32'd0, 32'd0, 32'd0, 1'b0);
        run_op(alu_pkg::OP_EXFF, alu_pkg::W_BYTE, 32'd0, 32'd0, 32'd0, 1'b0);

        for (wi = 0; wi < 3; wi++) begin // every count at every width
            for (n = 1; n <= 16; n++) begin
                o        = alu_pkg::alu_op_t'(int'(alu_pkg::OP_RLC) + rand_below(8));
                im       = rand32();
                im[3:0]  = n[3:0];
                run_op(o, 3'b001 << wi, rand32(), rand32(), im, 1'b1);
            end
        end

        for (i = 0; i < 600; i++) begin
            o  = alu_pkg::alu_op_t'(rand_below(31));
            wd = 3'b001 << rand_below(3);
            d  = rand32();
            s  = rand32();
            im = rand32();
            si = rand_below(2) == 1;
            if (o inside {alu_pkg::OP_INC, alu_pkg::OP_DEC}) begin
                im = 32'd1 + rand_below(8); // quick value 1..8
                si = 1'b1;
            end
            run_op(o, wd, d, s, im, si);
        end

        $display("%0d operations run, %0d errors", ops_run, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
source/alu_pkg.sv
source/alu_ctrl.sv
source/alu_addsub.sv
source/alu_bitlogic.sv
source/alu_shifter.sv
source/alu_flags.sv
source/alu_top.sv
bench/alu_tb.sv

//--- source/alu_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module alu_addsub (
    input  alu_pkg::alu_op_t             op,
    input  alu_pkg::width_t              w,
    input  logic [alu_pkg::DATA_W-1:0]   op0,
    input  logic [alu_pkg::DATA_W-1:0]   op2,
    input  logic                         carry_in,
    output logic [alu_pkg::DATA_W-1:0]   arith_result,
    output logic [alu_pkg::FLAG_W-1:0]   arith_flags
);

    logic        sub;
    logic        neg;
    logic        use_c;
    logic        keep_c;
    logic [31:0] a;
    logic [31:0] bx;
    logic [31:0] sum;
    logic [32:0] ext;
    logic        c0;
    logic        c4;
    logic        c8;
    logic        c16;
    logic        c32;
    logic        cw;

    function automatic logic [32:0] sx(input logic [31:0] x, input alu_pkg::width_t wd);
        return wd[0] ? {{25{x[7]}}, x[7:0]} : wd[1] ? {{17{x[15]}}, x[15:0]} : {x[31], x};
    endfunction

    assign sub    = op inside {alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP,
                               alu_pkg::OP_DEC, alu_pkg::OP_NEG};
    assign neg    = op == alu_pkg::OP_NEG;
    assign use_c  = op inside {alu_pkg::OP_ADC, alu_pkg::OP_SBC};
    assign keep_c = op inside {alu_pkg::OP_INC, alu_pkg::OP_DEC};
    assign a      = neg ? 32'd0 : op0; // NEG is 0 - op0
    assign bx     = sub ? ~(neg ? op0 : op2) : op2;
    assign c0     = sub ^ (use_c & carry_in); // subtract as a + ~b + 1

    always_comb begin
        {c4, sum[3:0]}    = {1'b0, a[3:0]} + {1'b0, bx[3:0]} + {4'd0, c0};
        {c8, sum[7:4]}    = {1'b0, a[7:4]} + {1'b0, bx[7:4]} + {4'd0, c4};
        {c16, sum[15:8]}  = {1'b0, a[15:8]} + {1'b0, bx[15:8]} + {8'd0, c8};
        {c32, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'd0, c16};
        ext = sx(a, w) + sx(bx, w) + {32'd0, c0};
    end

    assign cw           = w[0] ? c8 : w[1] ? c16 : c32;
    assign arith_result = (op == alu_pkg::OP_MOVE) ? op2 : sum;

    always_comb begin
        arith_flags[alu_pkg::FLAG_S] = alu_pkg::sign_of(sum, w);
        arith_flags[alu_pkg::FLAG_Z] = alu_pkg::zero_of(sum, w);
        arith_flags[alu_pkg::FLAG_H] = c4 ^ sub; // borrow on subtract
        arith_flags[alu_pkg::FLAG_V] = ext[32] ^ alu_pkg::sign_of(sum, w);
        arith_flags[alu_pkg::FLAG_N] = sub;
        arith_flags[alu_pkg::FLAG_C] = keep_c ? carry_in : cw ^ sub;
    end

endmodule

`default_nettype wire

//--- source/alu_bitlogic.sv
`timescale 1ns/1ps
`default_nettype none

module alu_bitlogic (
    input  alu_pkg::alu_op_t             op,
    input  alu_pkg::width_t              w,
    input  logic [alu_pkg::DATA_W-1:0]   op0,
    input  logic [alu_pkg::DATA_W-1:0]   op2,
    input  logic [alu_pkg::FLAG_W-1:0]   cur_flags,
    output logic [alu_pkg::DATA_W-1:0]   logic_result,
    output logic [alu_pkg::FLAG_W-1:0]   logic_flags
);

    logic [3:0]                 idx;
    logic [alu_pkg::DATA_W-1:0] r;

    assign idx = op2[3:0]; // bit number
    assign logic_result = r;

    always_comb begin
        r           = op0;
        logic_flags = cur_flags;
        case (op)
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
                r = (op == alu_pkg::OP_AND) ? op0 & op2 :
                    (op == alu_pkg::OP_OR)  ? op0 | op2 : op0 ^ op2;
                logic_flags[alu_pkg::FLAG_S] = alu_pkg::sign_of(r, w);
                logic_flags[alu_pkg::FLAG_Z] = alu_pkg::zero_of(r, w);
                logic_flags[alu_pkg::FLAG_H] = (op == alu_pkg::OP_AND);
                logic_flags[alu_pkg::FLAG_V] = alu_pkg::parity_of(r, w);
                logic_flags[alu_pkg::FLAG_N] = 1'b0;
                logic_flags[alu_pkg::FLAG_C] = 1'b0;
            end
            alu_pkg::OP_CPL: begin
                r = ~op0;
                logic_flags[alu_pkg::FLAG_H] = 1'b1;
                logic_flags[alu_pkg::FLAG_N] = 1'b1;
            end
            alu_pkg::OP_BIT, alu_pkg::OP_TSET: begin
                if (op == alu_pkg::OP_TSET) begin
                    r[idx] = 1'b1;
                end
                logic_flags[alu_pkg::FLAG_Z] = ~op0[idx]; // tested before the set
                logic_flags[alu_pkg::FLAG_H] = 1'b1;
                logic_flags[alu_pkg::FLAG_N] = 1'b0;
            end
            alu_pkg::OP_SET: r[idx] = 1'b1;
            alu_pkg::OP_RES: r[idx] = 1'b0;
            alu_pkg::OP_CHG: r[idx] = ~op0[idx];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  alu_pkg::alu_op_t             op,
    input  alu_pkg::width_t              w,
    input  logic [alu_pkg::DATA_W-1:0]   op1,
    input  logic [alu_pkg::DATA_W-1:0]   imm,
    input  logic                         sel_imm,
    input  logic [alu_pkg::DATA_W-1:0]   arith_result,
    input  logic [alu_pkg::DATA_W-1:0]   logic_result,
    input  logic [alu_pkg::DATA_W-1:0]   shift_result,
    input  logic [alu_pkg::FLAG_W-1:0]   arith_flags,
    input  logic [alu_pkg::FLAG_W-1:0]   logic_flags,
    input  logic [alu_pkg::FLAG_W-1:0]   shift_flags,
    input  logic [alu_pkg::FLAG_W-1:0]   cur_flags,
    input  logic                         busy,
    input  logic                         shift_done,
    output logic [alu_pkg::DATA_W-1:0]   op2,
    output logic [alu_pkg::DATA_W-1:0]   dout,
    output alu_pkg::width_t              result_we,
    output logic                         shift_start,
    output alu_pkg::alu_op_t             shift_kind,
    output logic [alu_pkg::FLAG_W-1:0]   flag_next,
    output logic                         flag_load,
    output logic                         flag_swap
);

    logic                       issue;
    logic                       is_shift;
    logic                       is_arith;
    logic                       writes;
    logic [alu_pkg::DATA_W-1:0] unit_result;
    logic [alu_pkg::FLAG_W-1:0] cand;
    alu_pkg::width_t            shift_w; // width of the shift in flight

    assign op2         = sel_imm ? imm : op1;
    assign issue       = (w != alu_pkg::W_NONE) && !busy; // strobes during a shift are dropped
    assign is_shift    = op inside {alu_pkg::OP_RLC, alu_pkg::OP_RRC, alu_pkg::OP_RL,
                                    alu_pkg::OP_RR, alu_pkg::OP_SLA, alu_pkg::OP_SRA,
                                    alu_pkg::OP_SLL, alu_pkg::OP_SRL};
    assign is_arith    = op inside {alu_pkg::OP_MOVE, alu_pkg::OP_ADD, alu_pkg::OP_ADC,
                                    alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP,
                                    alu_pkg::OP_INC, alu_pkg::OP_DEC, alu_pkg::OP_NEG};
    assign writes      = !(op inside {alu_pkg::OP_CP, alu_pkg::OP_BIT, alu_pkg::OP_SCF,
                                      alu_pkg::OP_RCF, alu_pkg::OP_CCF, alu_pkg::OP_ZCF,
                                      alu_pkg::OP_EXFF});
    assign shift_start = issue && is_shift;
    assign shift_kind  = op;
    assign unit_result = is_arith ? arith_result : logic_result;

    always_comb begin
        cand = cur_flags;
        case (op)
            alu_pkg::OP_INC, alu_pkg::OP_DEC: begin
                if (w[0]) begin
                    cand = arith_flags;
                end else begin
                    cand[alu_pkg::FLAG_H] = arith_flags[alu_pkg::FLAG_H]; // only H moves
                end
            end
            alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBC,
            alu_pkg::OP_CP, alu_pkg::OP_NEG: cand = arith_flags;
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR, alu_pkg::OP_CPL,
            alu_pkg::OP_BIT, alu_pkg::OP_SET, alu_pkg::OP_RES, alu_pkg::OP_CHG,
            alu_pkg::OP_TSET: cand = logic_flags;
            alu_pkg::OP_SCF, alu_pkg::OP_RCF: begin
                cand[alu_pkg::FLAG_C] = (op == alu_pkg::OP_SCF);
                cand[alu_pkg::FLAG_H] = 1'b0;
                cand[alu_pkg::FLAG_N] = 1'b0;
            end
            alu_pkg::OP_CCF: begin
                cand[alu_pkg::FLAG_C] = ~cur_flags[alu_pkg::FLAG_C];
                cand[alu_pkg::FLAG_N] = 1'b0;
            end
            alu_pkg::OP_ZCF: begin
                cand[alu_pkg::FLAG_C] = ~cur_flags[alu_pkg::FLAG_Z];
                cand[alu_pkg::FLAG_N] = 1'b0;
            end
            default: ;
        endcase
    end

    assign flag_next = shift_done ? shift_flags : cand;
    assign flag_load = shift_done || (issue && !is_shift && op != alu_pkg::OP_MOVE
                                      && op != alu_pkg::OP_EXFF);
    assign flag_swap = issue && op == alu_pkg::OP_EXFF;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            result_we <= alu_pkg::W_NONE;
            shift_w   <= alu_pkg::W_NONE;
        end else begin
            result_we <= alu_pkg::W_NONE;
            if (shift_start) begin
                shift_w <= w;
            end
            if (shift_done) begin
                dout      <= shift_result;
                result_we <= shift_start ? w : shift_w; // single step ends on issue
            end else if (issue && !is_shift && writes) begin
                dout      <= unit_result;
                result_we <= w;
            end
        end
    end

    a_w_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(w));

    // the source has no back-pressure and must stay idle during a shift
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> w == alu_pkg::W_NONE);

endmodule

`default_nettype wire

//--- source/alu_flags.sv
`timescale 1ns/1ps
`default_nettype none

module alu_flags (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [alu_pkg::FLAG_W-1:0]   flag_next,
    input  logic                         flag_load,
    input  logic                         flag_swap,
    output logic [alu_pkg::FLAG_W-1:0]   cur_flags,
    output logic [7:0]                   flags
);

    logic [alu_pkg::FLAG_W-1:0] f;
    logic [alu_pkg::FLAG_W-1:0] f_dash; // shadow F'

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f      <= '0;
            f_dash <= '0;
        end else if (flag_swap) begin
            f      <= f_dash;
            f_dash <= f;
        end else if (flag_load) begin
            f <= flag_next;
        end
    end

    assign cur_flags = f;

    // external layout S Z - H - V N C
    assign flags = {f[alu_pkg::FLAG_S], f[alu_pkg::FLAG_Z], 1'b0, f[alu_pkg::FLAG_H],
                    1'b0, f[alu_pkg::FLAG_V], f[alu_pkg::FLAG_N], f[alu_pkg::FLAG_C]};

    a_load_xor_swap: assert property (@(posedge clk) disable iff (rst)
        !(flag_load && flag_swap));

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int DATA_W = 32;
    localparam int FLAG_W = 6;

    // positions inside the stored flag vector
    localparam int FLAG_S = 5;
    localparam int FLAG_Z = 4;
    localparam int FLAG_H = 3;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    typedef logic [2:0] width_t; // one-hot operand width

    localparam width_t W_NONE = 3'b000;
    localparam width_t W_BYTE = 3'b001;
    localparam width_t W_WORD = 3'b010;
    localparam width_t W_LONG = 3'b100;

    typedef enum logic [4:0] {
        OP_MOVE, OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_INC, OP_DEC, OP_NEG,
        OP_AND, OP_OR, OP_XOR, OP_CPL,
        OP_BIT, OP_SET, OP_RES, OP_CHG, OP_TSET,
        OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SLL, OP_SRL,
        OP_SCF, OP_RCF, OP_CCF, OP_ZCF, OP_EXFF
    } alu_op_t;

    function automatic logic sign_of(input logic [DATA_W-1:0] x, input width_t wd);
        return wd[0] ? x[7] : wd[1] ? x[15] : x[31];
    endfunction

    function automatic logic zero_of(input logic [DATA_W-1:0] x, input width_t wd);
        return wd[0] ? x[7:0] == 8'd0 : wd[1] ? x[15:0] == 16'd0 : x == '0;
    endfunction

    // long width reuses the word parity
    function automatic logic parity_of(input logic [DATA_W-1:0] x, input width_t wd);
        return wd[0] ? ~^x[7:0] : ~^x[15:0];
    endfunction

endpackage

`default_nettype wire

//--- source/alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         shift_start,
    input  alu_pkg::alu_op_t             shift_kind,
    input  alu_pkg::width_t              w,
    input  logic [alu_pkg::DATA_W-1:0]   op0,
    input  logic [3:0]                   count,
    input  logic                         carry_in,
    output logic [alu_pkg::DATA_W-1:0]   shift_result,
    output logic [alu_pkg::FLAG_W-1:0]   shift_flags,
    output logic                         busy,
    output logic                         shift_done
);

    logic [3:0]                 cnt; // steps still to go after this one
    logic [alu_pkg::DATA_W-1:0] work;
    logic [alu_pkg::DATA_W-1:0] src;
    logic [alu_pkg::DATA_W-1:0] res;
    logic                       run_c;
    logic                       cin;
    logic                       msb;
    logic                       fill;
    logic                       out_bit;
    alu_pkg::alu_op_t           kind_q;
    alu_pkg::alu_op_t           kind;
    alu_pkg::width_t            wd_q;
    alu_pkg::width_t            wd;

    // first step works straight from the operands
    assign src  = shift_start ? op0 : work;
    assign cin  = shift_start ? carry_in : run_c;
    assign kind = shift_start ? shift_kind : kind_q;
    assign wd   = shift_start ? w : wd_q;
    assign msb  = alu_pkg::sign_of(src, wd);

    always_comb begin
        fill    = 1'b0;
        out_bit = src[0];
        if (kind inside {alu_pkg::OP_RLC, alu_pkg::OP_RL, alu_pkg::OP_SLA, alu_pkg::OP_SLL}) begin
            out_bit = msb;
            if (kind == alu_pkg::OP_RLC) begin
                fill = msb;
            end else if (kind == alu_pkg::OP_RL) begin
                fill = cin;
            end
            res = {src[30:0], fill};
        end else begin
            case (kind)
                alu_pkg::OP_RRC: fill = src[0];
                alu_pkg::OP_RR:  fill = cin;
                alu_pkg::OP_SRA: fill = msb;
                default: ;
            endcase
            res = {1'b0, src[31:1]};
            if (wd[0]) begin
                res[7] = fill;
            end else if (wd[1]) begin
                res[15] = fill;
            end else begin
                res[31] = fill;
            end
        end
    end

    assign shift_result = res;
    assign shift_done   = shift_start ? (count == 4'd1) : (busy && cnt == 4'd1);

    always_comb begin
        shift_flags[alu_pkg::FLAG_S] = alu_pkg::sign_of(res, wd);
        shift_flags[alu_pkg::FLAG_Z] = alu_pkg::zero_of(res, wd);
        shift_flags[alu_pkg::FLAG_H] = 1'b0;
        shift_flags[alu_pkg::FLAG_V] = alu_pkg::parity_of(res, wd);
        shift_flags[alu_pkg::FLAG_N] = 1'b0;
        shift_flags[alu_pkg::FLAG_C] = out_bit;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
        end else if (shift_start) begin
            cnt  <= count - 4'd1; // count 0 means 16
            busy <= count != 4'd1;
        end else if (busy) begin
            cnt  <= cnt - 4'd1;
            busy <= cnt != 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_start || busy) begin
            work  <= res;
            run_c <= out_bit;
        end
        if (shift_start) begin
            kind_q <= shift_kind;
            wd_q   <= w;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  logic                         clk,
    input  logic                         rst,
    input  alu_pkg::alu_op_t             op,
    input  alu_pkg::width_t              w,
    input  logic [alu_pkg::DATA_W-1:0]   op0,       // destination
    input  logic [alu_pkg::DATA_W-1:0]   op1,       // source
    input  logic [alu_pkg::DATA_W-1:0]   imm,
    input  logic                         sel_imm,
    output logic [alu_pkg::DATA_W-1:0]   dout,
    output alu_pkg::width_t              result_we,
    output logic [7:0]                   flags,
    output logic                         busy
);

    logic [alu_pkg::DATA_W-1:0] op2;
    logic [alu_pkg::DATA_W-1:0] arith_result;
    logic [alu_pkg::DATA_W-1:0] logic_result;
    logic [alu_pkg::DATA_W-1:0] shift_result;
    logic [alu_pkg::FLAG_W-1:0] arith_flags;
    logic [alu_pkg::FLAG_W-1:0] logic_flags;
    logic [alu_pkg::FLAG_W-1:0] shift_flags;
    logic [alu_pkg::FLAG_W-1:0] cur_flags;
    logic [alu_pkg::FLAG_W-1:0] flag_next;
    logic                       flag_load;
    logic                       flag_swap;
    logic                       shift_start;
    logic                       shift_done;
    alu_pkg::alu_op_t           shift_kind;

    alu_ctrl u_ctrl (
        .clk, .rst, .op, .w, .op1, .imm, .sel_imm,
        .arith_result, .logic_result, .shift_result,
        .arith_flags, .logic_flags, .shift_flags, .cur_flags,
        .busy, .shift_done, .op2, .dout, .result_we,
        .shift_start, .shift_kind, .flag_next, .flag_load, .flag_swap
    );

    alu_addsub u_addsub (
        .op, .w, .op0, .op2,
        .carry_in (cur_flags[alu_pkg::FLAG_C]),
        .arith_result, .arith_flags
    );

    alu_bitlogic u_bitlogic (
        .op, .w, .op0, .op2, .cur_flags, .logic_result, .logic_flags
    );

    alu_shifter u_shifter (
        .clk, .rst, .shift_start, .shift_kind, .w, .op0,
        .count    (op2[3:0]),  // 0 means 16 steps
        .carry_in (cur_flags[alu_pkg::FLAG_C]),
        .shift_result, .shift_flags, .busy, .shift_done
    );

    alu_flags u_flags (
        .clk, .rst, .flag_next, .flag_load, .flag_swap, .cur_flags, .flags
    );

endmodule

`default_nettype wire
